//--- Bender.yml
package:
  name: engine_csr_index

sources:
  # Package first, then blocks, then the top level
  - hw/csr_index_pkg.sv
  - hw/csr_index_config.sv
  - hw/csr_index_generator.sv
  - hw/packet_fifo.sv
  - hw/request_issue.sv
  - hw/engine_csr_index.sv

  - target: test
    files:
      - test/engine_csr_index_sva.sv
      - test/engine_csr_index_tb.sv

//--- engine_csr_index.f
hw/csr_index_pkg.sv
hw/csr_index_config.sv
hw/csr_index_generator.sv
hw/packet_fifo.sv
hw/request_issue.sv
hw/engine_csr_index.sv
test/engine_csr_index_sva.sv
test/engine_csr_index_tb.sv

//--- hw/csr_index_config.sv
// Capture of the range and base-address configuration words
`timescale 1ns/1ps

module csr_index_config (
    input  logic                                 ap_clk,
    input  logic                                 areset_csr_engine,
    // Memory response carrying configuration
    input  logic                                 cfg_valid_i,
    input  logic [csr_index_pkg::CFG_ID_W-1:0]   cfg_id_i,
    input  csr_index_pkg::cfg_word_u             cfg_data_i,
    // Consumes the transient range word
    input  logic                                 range_clear_i,
    output logic                                 range_valid_o,
    output logic                                 base_valid_o,
    output logic [csr_index_pkg::INDEX_W-1:0]    index_start_o,
    output logic [csr_index_pkg::INDEX_W-1:0]    index_end_o,
    output logic [csr_index_pkg::ADDR_W-1:0]     base_addr_o
);

    logic range_hit;
    logic base_hit;

    // ----------------------------------------
    // Word decode by ID
    // ----------------------------------------
    assign range_hit = cfg_valid_i && (cfg_id_i == csr_index_pkg::CFG_ID_RANGE);
    assign base_hit  = cfg_valid_i && (cfg_id_i == csr_index_pkg::CFG_ID_BASE);

    // ----------------------------------------
    // Slot flags
    // ----------------------------------------
    // A fresh range word wins over a clear in the same cycle
    always_ff @(posedge ap_clk) begin
        if (areset_csr_engine) begin
            range_valid_o <= 1'b0;
        end else if (range_hit) begin
            range_valid_o <= 1'b1;
        end else if (range_clear_i) begin
            range_valid_o <= 1'b0;
        end
    end

    // Base slot only drops on reset
    always_ff @(posedge ap_clk) begin
        if (areset_csr_engine) begin
            base_valid_o <= 1'b0;
        end else if (base_hit) begin
            base_valid_o <= 1'b1;
        end
    end

    // ----------------------------------------
    // Slot contents
    // ----------------------------------------
    always_ff @(posedge ap_clk) begin
        if (range_hit) begin
            index_start_o <= cfg_data_i.range_view.index_start;
            index_end_o   <= cfg_data_i.range_view.index_end;
        end
    end

    always_ff @(posedge ap_clk) begin
        if (base_hit) begin
            base_addr_o <= cfg_data_i.addr_view;
        end
    end

endmodule : csr_index_config

//--- hw/csr_index_generator.sv
// Index range walker that turns each vertex index into a read request
`timescale 1ns/1ps

module csr_index_generator (
    input  logic                                 ap_clk,
    input  logic                                 areset_csr_engine,
    // Kernel descriptor strobe
    input  logic                                 start_i,
    // Held configuration
    input  logic                                 range_valid_i,
    input  logic                                 base_valid_i,
    input  logic [csr_index_pkg::INDEX_W-1:0]    index_start_i,
    input  logic [csr_index_pkg::INDEX_W-1:0]    index_end_i,
    input  logic [csr_index_pkg::ADDR_W-1:0]     base_addr_i,
    // FIFO above threshold
    input  logic                                 prog_full_i,
    output logic                                 range_clear_o,
    output logic                                 push_o,
    output logic [csr_index_pkg::REQ_W-1:0]      push_data_o,
    output logic                                 busy_o
);

    logic                              start_q;
    logic                              accept;
    logic                              more;
    logic [csr_index_pkg::INDEX_W-1:0] idx_q;
    logic [csr_index_pkg::INDEX_W-1:0] end_q;
    logic [csr_index_pkg::ADDR_W-1:0]  base_q;
    logic [csr_index_pkg::ADDR_W-1:0]  idx_offset;
    logic [csr_index_pkg::ADDR_W-1:0]  req_addr;

    // ----------------------------------------
    // Start acceptance
    // ----------------------------------------
    always_ff @(posedge ap_clk) begin
        if (areset_csr_engine) begin
            start_q <= 1'b0;
        end else begin
            start_q <= start_i;
        end
    end

    // Dropped unless idle with both words held
    assign accept        = start_q && !busy_o && range_valid_i && base_valid_i;
    assign range_clear_o = accept;

    // ----------------------------------------
    // Index walk
    // ----------------------------------------
    assign more   = (idx_q < end_q);
    assign push_o = busy_o && more && !prog_full_i;

    always_ff @(posedge ap_clk) begin
        if (areset_csr_engine) begin
            busy_o <= 1'b0;
            idx_q  <= '0;
        end else if (accept) begin
            busy_o <= 1'b1;
            idx_q  <= index_start_i;
        end else begin
            if (push_o) begin
                idx_q <= idx_q + 1'b1;
            end
            // Also covers an empty range, which ends without a push
            if (busy_o && !more) begin
                busy_o <= 1'b0;
            end
        end
    end

    // End index and base are frozen for the whole run
    always_ff @(posedge ap_clk) begin
        if (accept) begin
            end_q  <= index_end_i;
            base_q <= base_addr_i;
        end
    end

    // ----------------------------------------
    // Request packet
    // ----------------------------------------
    assign idx_offset = csr_index_pkg::ADDR_W'(idx_q)
                      * csr_index_pkg::ADDR_W'(csr_index_pkg::INDEX_BYTES);
    assign req_addr   = base_q + idx_offset;

    // Address in the upper bits, index in the lower bits
    assign push_data_o = {req_addr, idx_q};

endmodule : csr_index_generator

//--- hw/csr_index_pkg.sv
// Widths, configuration IDs, FIFO sizing and the configuration word union
package csr_index_pkg;

    // ----------------------------------------
    // Data path widths
    // ----------------------------------------
    localparam int DATA_W   = 32;
    localparam int ADDR_W   = 32;
    localparam int INDEX_W  = 16;
    localparam int CFG_ID_W = 2;

    // One FIFO entry carries the address above the index
    localparam int REQ_W = ADDR_W + INDEX_W;

    // ----------------------------------------
    // Configuration word IDs
    // ----------------------------------------
    // Transient, consumed by one run
    localparam logic [CFG_ID_W-1:0] CFG_ID_RANGE = 2'd0;
    // Permanent, kept across runs
    localparam logic [CFG_ID_W-1:0] CFG_ID_BASE  = 2'd1;

    // Byte stride of the index array
    localparam int INDEX_BYTES = 4;

    // ----------------------------------------
    // Request FIFO sizing
    // ----------------------------------------
    localparam int FIFO_DEPTH       = 16;
    // Half the depth, so pushes in flight never overflow
    localparam int FIFO_PROG_THRESH = 8;

    // ----------------------------------------
    // Configuration word, two views
    // ----------------------------------------
    typedef union packed {
        // Range word
        struct packed {
            logic [INDEX_W-1:0] index_end;
            logic [INDEX_W-1:0] index_start;
        } range_view;
        // Base-address word
        logic [ADDR_W-1:0] addr_view;
    } cfg_word_u;

endpackage : csr_index_pkg

//--- hw/engine_csr_index.sv
// CSR index engine top with config capture, generator, request FIFO and issue stage
`timescale 1ns/1ps

module engine_csr_index (
    input  logic                                 ap_clk,
    input  logic                                 areset_csr_engine,
    input  logic                                 descriptor_valid_i,
    input  logic                                 cfg_valid_i,
    input  logic [csr_index_pkg::CFG_ID_W-1:0]   cfg_id_i,
    input  logic [csr_index_pkg::DATA_W-1:0]     cfg_data_i,
    input  logic                                 rd_en_i,
    output logic                                 req_valid_o,
    output logic [csr_index_pkg::ADDR_W-1:0]     req_addr_o,
    output logic [csr_index_pkg::INDEX_W-1:0]    req_index_o,
    output logic                                 done_o
);

    // ----------------------------------------
    // Config to generator
    // ----------------------------------------
    logic                              range_valid;
    logic                              base_valid;
    logic [csr_index_pkg::INDEX_W-1:0] index_start;
    logic [csr_index_pkg::INDEX_W-1:0] index_end;
    logic [csr_index_pkg::ADDR_W-1:0]  base_addr;
    logic                              range_clear;

    // ----------------------------------------
    // Generator, FIFO and issue stage
    // ----------------------------------------
    logic                              push;
    logic [csr_index_pkg::REQ_W-1:0]   push_data;
    logic                              busy;
    logic                              prog_full;
    logic                              full;
    logic                              empty;
    logic [csr_index_pkg::REQ_W-1:0]   head_data;
    logic                              pop;

    csr_index_config i_config (
        .ap_clk           (ap_clk),
        .areset_csr_engine(areset_csr_engine),
        .cfg_valid_i      (cfg_valid_i),
        .cfg_id_i         (cfg_id_i),
        .cfg_data_i       (csr_index_pkg::cfg_word_u'(cfg_data_i)),
        .range_clear_i    (range_clear),
        .range_valid_o    (range_valid),
        .base_valid_o     (base_valid),
        .index_start_o    (index_start),
        .index_end_o      (index_end),
        .base_addr_o      (base_addr)
    );

    csr_index_generator i_generator (
        .ap_clk           (ap_clk),
        .areset_csr_engine(areset_csr_engine),
        .start_i          (descriptor_valid_i),
        .range_valid_i    (range_valid),
        .base_valid_i     (base_valid),
        .index_start_i    (index_start),
        .index_end_i      (index_end),
        .base_addr_i      (base_addr),
        .prog_full_i      (prog_full),
        .range_clear_o    (range_clear),
        .push_o           (push),
        .push_data_o      (push_data),
        .busy_o           (busy)
    );

    packet_fifo #(
        .WIDTH      (csr_index_pkg::REQ_W),
        .DEPTH      (csr_index_pkg::FIFO_DEPTH),
        .PROG_THRESH(csr_index_pkg::FIFO_PROG_THRESH)
    ) i_fifo (
        .ap_clk           (ap_clk),
        .areset_csr_engine(areset_csr_engine),
        .push_i           (push),
        .push_data_i      (push_data),
        .pop_i            (pop),
        .head_data_o      (head_data),
        .empty_o          (empty),
        .full_o           (full),
        .prog_full_o      (prog_full)
    );

    request_issue i_issue (
        .ap_clk           (ap_clk),
        .areset_csr_engine(areset_csr_engine),
        .rd_en_i          (rd_en_i),
        .empty_i          (empty),
        .head_data_i      (head_data),
        .busy_i           (busy),
        .pop_o            (pop),
        .req_valid_o      (req_valid_o),
        .req_addr_o       (req_addr_o),
        .req_index_o      (req_index_o),
        .done_o           (done_o)
    );

endmodule : engine_csr_index

//--- hw/packet_fifo.sv
// Synchronous circular FIFO with full, empty and programmable-full flags
`timescale 1ns/1ps

module packet_fifo #(
    parameter int WIDTH       = csr_index_pkg::REQ_W,
    parameter int DEPTH       = csr_index_pkg::FIFO_DEPTH,
    parameter int PROG_THRESH = csr_index_pkg::FIFO_PROG_THRESH
) (
    input  logic             ap_clk,
    input  logic             areset_csr_engine,
    input  logic             push_i,
    input  logic [WIDTH-1:0] push_data_i,
    input  logic             pop_i,
    output logic [WIDTH-1:0] head_data_o,
    output logic             empty_o,
    output logic             full_o,
    output logic             prog_full_o
);

    localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int CNT_W = $clog2(DEPTH + 1);

    logic [WIDTH-1:0] mem [DEPTH];
    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [CNT_W-1:0] count;
    logic [CNT_W-1:0] count_next;

    // ----------------------------------------
    // Storage
    // ----------------------------------------
    always_ff @(posedge ap_clk) begin
        if (push_i) begin
            mem[wr_ptr] <= push_data_i;
        end
    end

    assign head_data_o = mem[rd_ptr];

    // ----------------------------------------
    // Pointers
    // ----------------------------------------
    // Explicit wrap so any depth works
    always_ff @(posedge ap_clk) begin
        if (areset_csr_engine) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
        end else begin
            if (push_i) begin
                wr_ptr <= (wr_ptr == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
            end
            if (pop_i) begin
                rd_ptr <= (rd_ptr == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
            end
        end
    end

    // ----------------------------------------
    // Occupancy and flags
    // ----------------------------------------
    always_comb begin
        count_next = count;
        if (push_i && !pop_i) begin
            count_next = count + 1'b1;
        end else if (pop_i && !push_i) begin
            count_next = count - 1'b1;
        end
    end

    // Flags follow the next count so they line up with the count
    always_ff @(posedge ap_clk) begin
        if (areset_csr_engine) begin
            count       <= '0;
            empty_o     <= 1'b1;
            full_o      <= 1'b0;
            prog_full_o <= 1'b0;
        end else begin
            count       <= count_next;
            empty_o     <= (count_next == '0);
            full_o      <= (count_next == CNT_W'(DEPTH));
            prog_full_o <= (count_next >= CNT_W'(PROG_THRESH));
        end
    end

endmodule : packet_fifo

//--- hw/request_issue.sv
// Request output stage that drains the FIFO and reports done
`timescale 1ns/1ps

module request_issue (
    input  logic                                 ap_clk,
    input  logic                                 areset_csr_engine,
    // Downstream read enable
    input  logic                                 rd_en_i,
    input  logic                                 empty_i,
    input  logic [csr_index_pkg::REQ_W-1:0]      head_data_i,
    // Generator still walking
    input  logic                                 busy_i,
    output logic                                 pop_o,
    output logic                                 req_valid_o,
    output logic [csr_index_pkg::ADDR_W-1:0]     req_addr_o,
    output logic [csr_index_pkg::INDEX_W-1:0]    req_index_o,
    output logic                                 done_o
);

    // ----------------------------------------
    // Pop control
    // ----------------------------------------
    // The FIFO has no underflow guard of its own
    assign pop_o = rd_en_i && !empty_i;

    // ----------------------------------------
    // Output register
    // ----------------------------------------
    always_ff @(posedge ap_clk) begin
        if (areset_csr_engine) begin
            req_valid_o <= 1'b0;
            done_o      <= 1'b1;
        end else begin
            req_valid_o <= pop_o;
            // Done waits for the last entry to leave the FIFO
            done_o      <= !busy_i && empty_i && !pop_o;
        end
    end

    // Entry split into address and index
    always_ff @(posedge ap_clk) begin
        if (pop_o) begin
            req_addr_o  <= head_data_i[csr_index_pkg::REQ_W-1 -: csr_index_pkg::ADDR_W];
            req_index_o <= head_data_i[csr_index_pkg::INDEX_W-1:0];
        end
    end

endmodule : request_issue

//--- test/engine_csr_index_sva.sv
// FIFO and output protocol assertions for the CSR index engine
`timescale 1ns/1ps

module engine_csr_index_sva (
    input  logic ap_clk,
    input  logic areset_csr_engine,
    input  logic push_i,
    input  logic full_i,
    input  logic pop_i,
    input  logic empty_i,
    input  logic req_valid_i,
    input  logic done_i
);

    // Read back by the testbench for the closing summary
    int sva_errors = 0;

    // ----------------------------------------
    // FIFO occupancy rules
    // ----------------------------------------
    // Pop side has no underflow guard in the FIFO
    no_pop_when_empty: assert property (
        @(posedge ap_clk) disable iff (areset_csr_engine)
        !(pop_i && empty_i)
    ) else begin
        sva_errors++;
        $error("FIFO popped while empty");
    end

    // Threshold at half depth keeps the generator clear of full
    no_push_when_full: assert property (
        @(posedge ap_clk) disable iff (areset_csr_engine)
        !(push_i && full_i)
    ) else begin
        sva_errors++;
        $error("FIFO pushed while full");
    end

    // ----------------------------------------
    // Output stage
    // ----------------------------------------
    no_request_while_done: assert property (
        @(posedge ap_clk) disable iff (areset_csr_engine)
        !(req_valid_i && done_i)
    ) else begin
        sva_errors++;
        $error("Request issued while done is high");
    end

endmodule : engine_csr_index_sva

//--- test/engine_csr_index_tb.sv
// Testbench for the CSR index engine with model counters, checking assertions and timeout
`timescale 1ns/1ps

module engine_csr_index_tb;

    localparam int CLK_HALF    = 50;
    localparam int DRIVE_DELAY = 1;
    localparam logic [15:0] R1_S = 16'd3;
    localparam logic [15:0] R1_E = 16'd23;
    localparam logic [15:0] R2_S = 16'd100;
    localparam logic [15:0] R2_E = 16'd130;
    localparam logic [15:0] R3_S = 16'd500;
    localparam logic [15:0] R3_E = 16'd512;
    localparam logic [15:0] R4_S = 16'd40;
    localparam logic [31:0] BASE_A = 32'h0004_2000;
    localparam int TIMEOUT_CYCLES =
        ((R1_E - R1_S) + (R2_E - R2_S) + (R3_E - R3_S)) * 4 + 200;

    logic ap_clk;
    logic areset_csr_engine;
    logic descriptor_valid_i;
    logic cfg_valid_i;
    logic [csr_index_pkg::CFG_ID_W-1:0] cfg_id_i;
    logic [csr_index_pkg::DATA_W-1:0]   cfg_data_i;
    logic rd_en_i = 1'b0;
    logic req_valid_o;
    logic [csr_index_pkg::ADDR_W-1:0]  req_addr_o;
    logic [csr_index_pkg::INDEX_W-1:0] req_index_o;
    logic done_o;

    // Model state
    logic [csr_index_pkg::INDEX_W-1:0] run_start;
    logic [csr_index_pkg::INDEX_W-1:0] exp_index;
    logic [csr_index_pkg::ADDR_W-1:0]  cur_base;
    logic [csr_index_pkg::ADDR_W-1:0]  exp_addr;
    int    run_len;
    int    req_seen;
    logic  model_load;
    logic  expect_idle;
    logic  hold_window;
    logic  check_count;
    logic  rd_hold;
    logic  hold_now;
    logic [31:0] rnd;
    integer seed = 29;
    int    cycle_count = 0;
    int    value_errors = 0;
    int    other_errors = 0;
    int    total_errors;
    string test_name;

    engine_csr_index i_dut (.*);

    bind engine_csr_index engine_csr_index_sva i_sva (
        .ap_clk           (ap_clk),
        .areset_csr_engine(areset_csr_engine),
        .push_i           (push),
        .full_i           (full),
        .pop_i            (pop),
        .empty_i          (empty),
        .req_valid_i      (req_valid_o),
        .done_i           (done_o)
    );

    always #CLK_HALF ap_clk = ~ap_clk;

    // Random read enable, forced low during a hold
    always @(posedge ap_clk) begin
        hold_now = rd_hold;
        rnd = $random(seed);
        #DRIVE_DELAY;
        rd_en_i = hold_now ? 1'b0 : rnd[0];
    end

    always @(posedge ap_clk) begin
        if (areset_csr_engine || model_load) begin
            req_seen <= 0;
        end else if (req_valid_o) begin
            req_seen <= req_seen + 1;
        end
    end

    // Next index follows the start, address follows base plus stride
    assign exp_index = run_start + csr_index_pkg::INDEX_W'(req_seen);
    assign exp_addr  = cur_base + csr_index_pkg::ADDR_W'(exp_index)
                     * csr_index_pkg::ADDR_W'(csr_index_pkg::INDEX_BYTES);

    // ----------------------------------------
    // Checks, sampled mid-cycle
    // ----------------------------------------
    index_order: assert property (@(negedge ap_clk) disable iff (areset_csr_engine)
        req_valid_o |-> req_index_o == exp_index)
    else begin
        value_errors++;
        $display("[FAIL] %s: index expected %0d, actual %0d", test_name, exp_index, req_index_o);
    end

    address_value: assert property (@(negedge ap_clk) disable iff (areset_csr_engine)
        req_valid_o |-> req_addr_o == exp_addr)
    else begin
        value_errors++;
        $display("[FAIL] %s: address expected %h, actual %h", test_name, exp_addr, req_addr_o);
    end

    request_in_range: assert property (@(negedge ap_clk) disable iff (areset_csr_engine)
        req_valid_o |-> req_seen < run_len)
    else begin
        other_errors++;
        $display("%s: a request appeared beyond the end of the range", test_name);
    end

    quiet_during_hold: assert property (@(negedge ap_clk) disable iff (areset_csr_engine)
        hold_window |-> !req_valid_o)
    else begin
        other_errors++;
        $display("%s: a request appeared while read enable was held low", test_name);
    end

    idle_outputs: assert property (@(negedge ap_clk) disable iff (areset_csr_engine)
        expect_idle |-> done_o && !req_valid_o)
    else begin
        other_errors++;
        $display("%s: engine left idle without an accepted start", test_name);
    end

    request_count: assert property (@(negedge ap_clk) disable iff (areset_csr_engine)
        check_count |-> req_seen == run_len)
    else begin
        value_errors++;
        $display("[FAIL] %s: request count expected %0d, actual %0d", test_name, run_len, req_seen);
    end

    always @(posedge ap_clk) begin
        cycle_count++;
        if (cycle_count >= TIMEOUT_CYCLES) begin
            $display("Timeout: the run did not finish within %0d cycles", TIMEOUT_CYCLES);
            $display("Checks failed");
            $finish;
        end
    end

    // ----------------------------------------
    // Stimulus tasks
    // ----------------------------------------
    task automatic next_cycle();
        @(posedge ap_clk);
        #DRIVE_DELAY;
    endtask

    task automatic write_config(input logic [1:0] id, input logic [31:0] data);
        cfg_valid_i = 1'b1;
        cfg_id_i    = id;
        cfg_data_i  = data;
        next_cycle();
        cfg_valid_i = 1'b0;
    endtask

    task automatic write_base(input logic [31:0] addr);
        cur_base = addr;
        write_config(csr_index_pkg::CFG_ID_BASE, addr);
    endtask

    // End index sits in the upper half of the word
    task automatic write_range(input logic [15:0] s, input logic [15:0] e);
        write_config(csr_index_pkg::CFG_ID_RANGE, {e, s});
    endtask

    task automatic pulse_descriptor();
        descriptor_valid_i = 1'b1;
        next_cycle();
        descriptor_valid_i = 1'b0;
    endtask

    task automatic start_run(input logic [15:0] s, input logic [15:0] e);
        run_start   = s;
        run_len     = int'(e) - int'(s);
        model_load  = 1'b1;
        expect_idle = 1'b0;
        pulse_descriptor();
        model_load  = 1'b0;
    endtask

    // Done drops after acceptance, then rises once drained
    task automatic wait_run_end();
        @(posedge ap_clk);
        while (done_o) @(posedge ap_clk);
        while (!done_o) @(posedge ap_clk);
        #DRIVE_DELAY;
        check_count = 1'b1;
        expect_idle = 1'b1;
        next_cycle();
        check_count = 1'b0;
    endtask

    task automatic hold_read_enable();
        rd_hold = 1'b1;
        next_cycle();
        next_cycle();
        hold_window = 1'b1;
        repeat (38) next_cycle();
        hold_window = 1'b0;
        rd_hold     = 1'b0;
    endtask

    initial begin
        ap_clk = 1'b0;
        areset_csr_engine = 1'b1;
        descriptor_valid_i = 1'b0;
        cfg_valid_i = 1'b0;
        cfg_id_i = '0;
        cfg_data_i = '0;
        run_start = '0;
        cur_base = '0;
        run_len = 0;
        model_load = 1'b0;
        expect_idle = 1'b1;
        hold_window = 1'b0;
        check_count = 1'b0;
        rd_hold = 1'b0;
        test_name = "reset_idle";
        repeat (8) @(posedge ap_clk);
        #DRIVE_DELAY;
        areset_csr_engine = 1'b0;
        repeat (4) next_cycle();

        test_name = "basic_run";
        write_base(BASE_A);
        write_range(R1_S, R1_E);
        start_run(R1_S, R1_E);
        wait_run_end();

        test_name = "backpressure";
        write_range(R2_S, R2_E);
        start_run(R2_S, R2_E);
        while (req_seen < 8) @(posedge ap_clk);
        #DRIVE_DELAY;
        hold_read_enable();
        wait_run_end();

        test_name = "retained_base";
        write_range(R3_S, R3_E);
        start_run(R3_S, R3_E);
        wait_run_end();

        // Range word already consumed
        test_name = "ignored_start";
        pulse_descriptor();
        repeat (10) next_cycle();

        test_name = "empty_range";
        write_range(R4_S, R4_S);
        start_run(R4_S, R4_S);
        wait_run_end();
        repeat (5) next_cycle();

        total_errors = value_errors + other_errors + i_dut.i_sva.sva_errors;
        $display("Errors: %0d value mismatches, %0d other failures, %0d protocol violations",
                 value_errors, other_errors, i_dut.i_sva.sva_errors);
        if (total_errors == 0) begin
            $display("All checks passed");
        end else begin
            $display("Checks failed");
        end
        $finish;
    end

endmodule : engine_csr_index_tb
